// ==== Bender.yml ====
package:
  name: h80

sources:
  - verilog/h80_pkg.sv
  - verilog/h80_regfile.sv
  - verilog/h80_alu.sv
  - verilog/h80_decode.sv
  - verilog/h80_control.sv
  - verilog/h80_cpu.sv
  - target: test
    files:
      - tb/h80_mem.sv
      - tb/h80_tb.sv

// ==== sim.f ====
verilog/h80_pkg.sv
verilog/h80_regfile.sv
verilog/h80_alu.sv
verilog/h80_decode.sv
verilog/h80_control.sv
verilog/h80_cpu.sv
tb/h80_mem.sv
tb/h80_tb.sv

// ==== tb/h80_mem.sv ====
`timescale 1ns/1ps

module h80_mem (
   input  logic              clk,
   input  h80_pkg::bus_req_t bus_req,
   output h80_pkg::word_t    bus_rdata
);

   import h80_pkg::*;

   localparam int depth = 256;
   localparam int idx_w = $clog2(depth);

   word_t words [depth];
   word_t rdata = '0;

   assign bus_rdata = rdata;

   // program loading from the testbench at time 0
   task automatic preload(int index, word_t value);
      words[index] = value;
   endtask

   always @(posedge clk) begin
      if (bus_req.strobe) begin
         if (bus_req.write) begin
            words[bus_req.addr[idx_w:1]] <= bus_req.wdata;  // byte address to word index
         end else begin
            rdata <= words[bus_req.addr[idx_w:1]];  // answer one cycle later
         end
      end
   end

endmodule

// ==== tb/h80_tb.sv ====
`timescale 1ns/1ps

module h80_tb;

   import h80_pkg::*;

   typedef struct packed {
      logic       write;
      word_t      addr;
      word_t      data;
      logic [1:0] gap;  // cycles since the previous strobe
   } bus_event_t;

   logic     clk;
   logic     reset;
   word_t    bus_rdata;
   bus_req_t bus_req;
   logic     halted;

   word_t      prog [$];
   bus_event_t expected [$];
   logic [1:0] next_gap;
   word_t      model_regs [num_regs];
   flags_t     model_flags;
   word_t      model_dmem [word_t];

   logic [16:0] lfsr_state  = 17'd80259;
   int          cycle       = 0;
   int          last_strobe = 0;
   int          cycle_limit = 0;

   h80_cpu dut_i (
      .clk       (clk),
      .reset     (reset),
      .bus_rdata (bus_rdata),
      .bus_req   (bus_req),
      .halted    (halted)
   );

   h80_mem mem_i (
      .clk       (clk),
      .bus_req   (bus_req),
      .bus_rdata (bus_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic stop_with_failure();
      $display("SOME TESTS FAILED");
      $fatal(1, "stopped at the first failure");
   endtask

   task automatic report_mismatch(string name, word_t got, word_t want);
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, want);
      stop_with_failure();
   endtask

   task automatic report_failure(string what);
      $display("** Error at %0t: %s", $time, what);
      stop_with_failure();
   endtask

   // 17-bit Fibonacci LFSR, taps 17 and 14
   function automatic logic lfsr_next_bit();
      logic fb;
      fb = lfsr_state[16] ^ lfsr_state[13];
      lfsr_state = {lfsr_state[15:0], fb};
      return fb;
   endfunction

   function automatic logic [7:0] rand_byte();
      logic [7:0] v;
      v = '0;
      for (int i = 0; i < 8; i++) begin
         v = {v[6:0], lfsr_next_bit()};
      end
      return v;
   endfunction

   // {flags, result} by the instruction set rules
   function automatic logic [19:0] alu_ref(logic [3:0] opc, word_t a, word_t b);
      word_t  r;
      flags_t f;
      int     s;
      f = '0;
      case (opc)
         4'h8: begin
            r = a + b;
            f[flag_carry] = (int'(a) + int'(b)) > 65535;
            s = int'($signed(a)) + int'($signed(b));
            f[flag_overflow] = (s > 32767) || (s < -32768);
         end
         4'h9, 4'hF: begin
            r = a - b;
            f[flag_carry] = a < b;  // borrow
            s = int'($signed(a)) - int'($signed(b));
            f[flag_overflow] = (s > 32767) || (s < -32768);
         end
         default: begin
            r = (opc == 4'hC) ? (a & b) : (opc == 4'hD) ? (a | b) : (a ^ b);
            f[flag_overflow] = ~^r;  // even parity
         end
      endcase
      f[flag_zero] = (r == '0);
      f[flag_sign] = r[15];
      return {f, r};
   endfunction

   task automatic expect_access(logic write, word_t addr, word_t data, logic [1:0] gap);
      bus_event_t ev;
      ev.write = write;
      ev.addr  = addr;
      ev.data  = data;
      ev.gap   = gap;
      expected.push_back(ev);
   endtask

   task automatic fetched(word_t ins);
      expect_access(1'b0, word_t'(2 * prog.size()), '0, next_gap);
      prog.push_back(ins);
      next_gap = 2'd2;
   endtask

   task automatic skipped(word_t ins);
      prog.push_back(ins);  // jumped over, never fetched
   endtask

   task automatic imm_load(reg_num_t d, logic [7:0] v, logic sext);
      fetched({sext ? 4'h2 : 4'h1, d, v});
      model_regs[d] = sext ? {{8{v[7]}}, v} : {8'h00, v};
   endtask

   task automatic store_word(reg_num_t a, reg_num_t b);
      fetched({8'h34, a, b});
      expect_access(1'b1, model_regs[b], model_regs[a], 2'd1);
      model_dmem[model_regs[b]] = model_regs[a];
      next_gap = 2'd1;
   endtask

   task automatic load_word(reg_num_t a, reg_num_t b);
      fetched({8'h36, a, b});
      expect_access(1'b0, model_regs[b], '0, 2'd1);
      model_regs[a] = model_dmem[model_regs[b]];
      next_gap = 2'd2;  // extra mem cycle before the next fetch
   endtask

   task automatic reg_move(logic dir_ba, reg_num_t a, reg_num_t b);
      if (dir_ba) begin
         fetched({8'h3E, a, b});
         model_regs[a] = model_regs[b];
      end else begin
         fetched({8'h3C, a, b});
         model_regs[b] = model_regs[a];
      end
   endtask

   // target register r15 points past a NOP, so taken and not taken fetch differently
   task automatic jump_over_nop(logic cond, logic [1:0] f, logic sense);
      logic taken;
      imm_load(4'hF, 8'(2 * prog.size() + 6), 1'b0);
      taken = !cond || (model_flags[f] == sense);
      if (cond) begin
         fetched({8'h03, 1'b0, sense, f, 4'hF});
      end else begin
         fetched(16'h01EF);
      end
      if (taken) begin
         skipped(16'h0000);
      end else begin
         fetched(16'h0000);
      end
   endtask

   task automatic alu_step(logic [3:0] opc, reg_num_t d, reg_num_t a, reg_num_t b);
      logic [19:0] out;
      out = alu_ref(opc, model_regs[a], model_regs[b]);
      fetched({opc, d, a, b});
      if (opc != 4'hF) begin
         model_regs[d] = out[15:0];
      end
      model_flags = out[19:16];
   endtask

   task automatic build_program();
      logic [3:0] alu_codes [6];
      int         slot;
      alu_codes = '{4'h8, 4'h9, 4'hC, 4'hD, 4'hE, 4'hF};
      slot = 0;
      foreach (model_regs[i]) begin
         model_regs[i] = '0;
      end
      model_flags = '0;
      next_gap = 2'd2;  // first fetch two cycles after the last reset cycle
      for (int i = 0; i < 4; i++) begin
         imm_load(4'h1, rand_byte(), i[0]);
         imm_load(4'hE, 8'(8'h80 + 2 * slot), 1'b1);  // data at 0xff80 and up
         store_word(4'h1, 4'hE);
         slot++;
      end
      for (int k = 0; k < 6; k++) begin
         imm_load(4'h1, rand_byte(), k[0]);
         imm_load(4'h2, rand_byte(), !k[0]);
         alu_step(alu_codes[k], 4'h3, 4'h1, 4'h2);
         imm_load(4'hE, 8'(8'h80 + 2 * slot), 1'b1);
         store_word(4'h3, 4'hE);
         slot++;
         for (int f = 0; f < 4; f++) begin
            jump_over_nop(1'b1, f[1:0], f[0] ^ k[0]);
         end
      end
      // ADD result back through a load and both move directions
      imm_load(4'hE, 8'h88, 1'b1);
      load_word(4'h5, 4'hE);
      reg_move(1'b0, 4'h5, 4'h6);
      reg_move(1'b1, 4'h7, 4'h6);
      imm_load(4'hE, 8'(8'h80 + 2 * slot), 1'b1);
      store_word(4'h7, 4'hE);
      jump_over_nop(1'b0, 2'd0, 1'b0);
      fetched(16'h0001);
   endtask

   task automatic check_strobe();
      bus_event_t ev;
      if (expected.size() == 0) begin
         report_failure("bus strobe after the last expected access");
      end else begin
         ev = expected.pop_front();
         assert (cycle - last_strobe == int'(ev.gap))
            else report_mismatch("cycles since last strobe", word_t'(cycle - last_strobe),
                                 word_t'(ev.gap));
         assert (bus_req.write == ev.write)
            else report_mismatch("bus_req.write", word_t'(bus_req.write), word_t'(ev.write));
         assert (bus_req.addr == ev.addr)
            else report_mismatch("bus_req.addr", bus_req.addr, ev.addr);
         if (ev.write) begin
            assert (bus_req.wdata == ev.data)
               else report_mismatch("bus_req.wdata", bus_req.wdata, ev.data);
         end
         last_strobe = cycle;
      end
   endtask

   always @(posedge clk) begin
      cycle++;
      if (cycle > cycle_limit) begin
         report_failure("timeout, the program did not reach HALT in time");
      end
      if (reset) begin
         last_strobe = cycle;
         if (cycle > 1) begin
            assert (!bus_req.strobe && !halted)
               else report_failure("strobe or halted high during reset");
         end
      end else begin
         if (halted && expected.size() != 0) begin
            report_failure("halted before the program finished");
         end
         if (bus_req.strobe) begin
            check_strobe();
         end
      end
   end

   halted_holds: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
      else report_failure("halted dropped without a reset");

   quiet_when_halted: assert property (@(posedge clk) disable iff (reset)
                                       halted |-> !bus_req.strobe)
      else report_failure("bus strobe while halted");

   initial begin
      reset = 1'b1;
      build_program();
      for (int i = 0; i < prog.size(); i++) begin
         mem_i.preload(i, prog[i]);
      end
      cycle_limit = 3 * prog.size() + 50;
      repeat (4) @(negedge clk);
      reset = 1'b0;
      while (!halted) begin
         @(posedge clk);
      end
      repeat (20) @(posedge clk);
      if (expected.size() != 0) begin
         report_failure("some expected bus accesses never happened");
      end else begin
         $display("ALL TESTS PASSED");
         $finish;
      end
   end

endmodule

// ==== verilog/h80_alu.sv ====
`timescale 1ns/1ps

module h80_alu (
   input  h80_pkg::word_t    a,
   input  h80_pkg::word_t    b,
   input  h80_pkg::alu_op_t  op,
   output h80_pkg::alu_out_t out
);

   import h80_pkg::*;

   localparam int sb = word_w - 1;  // sign bit

   logic [word_w:0] a_x;
   logic [word_w:0] b_x;
   logic [word_w:0] res;  // extra bit catches carry/borrow

   assign a_x = {1'b0, a};
   assign b_x = {1'b0, b};

   always_comb begin
      case (op)
         alu_add:         res = a_x + b_x;
         alu_sub, alu_cp: res = a_x - b_x;
         alu_and:         res = a_x & b_x;
         alu_or:          res = a_x | b_x;
         alu_xor:         res = a_x ^ b_x;
         default:         res = '0;
      endcase
   end

   always_comb begin
      out.result                = res[sb:0];
      out.flags[flag_zero]      = (res[sb:0] == '0);
      out.flags[flag_sign]      = res[sb];
      case (op)
         alu_add: begin
            out.flags[flag_carry]    = res[word_w];
            out.flags[flag_overflow] = (a[sb] == b[sb]) && (res[sb] != a[sb]);
         end
         alu_sub, alu_cp: begin
            out.flags[flag_carry]    = res[word_w];  // borrow
            out.flags[flag_overflow] = (a[sb] != b[sb]) && (res[sb] != a[sb]);
         end
         default: begin
            // logic ops report even parity in the overflow bit
            out.flags[flag_carry]    = 1'b0;
            out.flags[flag_overflow] = ~^res[sb:0];
         end
      endcase
   end

endmodule

// ==== verilog/h80_control.sv ====
`timescale 1ns/1ps

module h80_control (
   input  logic              clk,
   input  logic              reset,
   input  h80_pkg::op_t      op,
   input  h80_pkg::word_t    rd_a,
   input  h80_pkg::word_t    rd_b,
   input  h80_pkg::alu_out_t alu_out,
   input  h80_pkg::word_t    bus_rdata,
   output h80_pkg::reg_wr_t  reg_wr,
   output h80_pkg::bus_req_t bus_req,
   output logic              halted
);

   import h80_pkg::*;

   typedef enum logic [1:0] {st_fetch, st_exec, st_mem, st_halt} state_t;

   state_t   state;
   word_t    pc;
   flags_t   flags;
   reg_num_t load_dst;  // destination of the pending load
   logic     jump_taken;
   word_t    next_pc;

   assign jump_taken = (op.kind == op_jump) &&
                       (!op.cond || (flags[op.flag_sel] == op.sense));
   assign next_pc    = jump_taken ? rd_a : pc + word_t'(2);

   always_comb begin
      bus_req = '0;
      case (state)
         st_fetch: begin
            bus_req.strobe = 1'b1;
            bus_req.addr   = pc;
         end
         st_exec: begin
            bus_req.strobe = (op.kind == op_load_mem) || (op.kind == op_store_mem);
            bus_req.write  = (op.kind == op_store_mem);
            bus_req.addr   = rd_b;
            bus_req.wdata  = rd_a;
         end
         default: bus_req = '0;
      endcase
   end

   always_comb begin
      reg_wr = '0;
      if (state == st_exec) begin
         reg_wr.num = op.dst;
         case (op.kind)
            op_load_imm: {reg_wr.en, reg_wr.data} = {1'b1, op.imm};
            op_move:     {reg_wr.en, reg_wr.data} = {1'b1, rd_a};
            op_alu:      {reg_wr.en, reg_wr.data} = {op.alu_op != alu_cp, alu_out.result};
            default:     reg_wr.en = 1'b0;
         endcase
      end else if (state == st_mem) begin
         reg_wr.en   = 1'b1;
         reg_wr.num  = load_dst;
         reg_wr.data = bus_rdata;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state  <= st_halt;  // idle until reset falls, halted stays low
         pc     <= '0;
         flags  <= '0;
         halted <= 1'b0;
      end else begin
         case (state)
            st_fetch: state <= st_exec;
            st_exec: begin
               pc <= next_pc;
               if (op.kind == op_alu) begin
                  flags <= alu_out.flags;
               end
               case (op.kind)
                  op_halt: begin
                     state  <= st_halt;
                     halted <= 1'b1;
                  end
                  op_load_mem: state <= st_mem;
                  default:     state <= st_fetch;
               endcase
            end
            st_mem: state <= st_fetch;
            default: begin
               if (!halted) begin
                  state <= st_fetch;  // first fetch after reset
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == st_exec && op.kind == op_load_mem) begin
         load_dst <= op.dst;
      end
   end

endmodule

// ==== verilog/h80_cpu.sv ====
`timescale 1ns/1ps

module h80_cpu (
   input  logic              clk,
   input  logic              reset,
   input  h80_pkg::word_t    bus_rdata,
   output h80_pkg::bus_req_t bus_req,
   output logic              halted
);

   import h80_pkg::*;

   op_t      op;
   word_t    rd_a;
   word_t    rd_b;
   alu_out_t alu_out;
   reg_wr_t  reg_wr;

   h80_decode decode_i (
      .ins (bus_rdata),  // instruction word during exec
      .op  (op)
   );

   h80_regfile regfile_i (
      .clk   (clk),
      .reset (reset),
      .src_a (op.src_a),
      .src_b (op.src_b),
      .wr    (reg_wr),
      .rd_a  (rd_a),
      .rd_b  (rd_b)
   );

   h80_alu alu_i (
      .a   (rd_a),
      .b   (rd_b),
      .op  (op.alu_op),
      .out (alu_out)
   );

   h80_control control_i (
      .clk       (clk),
      .reset     (reset),
      .op        (op),
      .rd_a      (rd_a),
      .rd_b      (rd_b),
      .alu_out   (alu_out),
      .bus_rdata (bus_rdata),
      .reg_wr    (reg_wr),
      .bus_req   (bus_req),
      .halted    (halted)
   );

endmodule

// ==== verilog/h80_decode.sv ====
`timescale 1ns/1ps

module h80_decode (
   input  h80_pkg::word_t ins,
   output h80_pkg::op_t   op
);

   import h80_pkg::*;

   always_comb begin
      op       = '0;           // nop unless matched
      op.dst   = ins[11:8];
      op.src_a = ins[7:4];
      op.src_b = ins[3:0];

      casez (ins)
         16'h0000: op.kind = op_nop;
         16'h0001: op.kind = op_halt;
         16'b0000_0001_1110_zzzz: begin  // JP R
            op.kind  = op_jump;
            op.src_a = ins[3:0];
         end
         16'b0000_0011_0zzz_zzzz: begin  // JPN f / JP f, target in R
            op.kind     = op_jump;
            op.cond     = 1'b1;
            op.sense    = ins[6];
            op.flag_sel = ins[5:4];
            op.src_a    = ins[3:0];
         end
         16'h1zzz: begin  // zero-extended immediate
            op.kind = op_load_imm;
            op.imm  = {8'h00, ins[7:0]};
         end
         16'h2zzz: begin  // sign-extended immediate
            op.kind = op_load_imm;
            op.imm  = {{8{ins[7]}}, ins[7:0]};
         end
         16'b0011_110z_zzzz_zzzz: begin  // move reg[a] to reg[b]
            op.kind  = op_move;
            op.src_a = ins[7:4];
            op.dst   = ins[3:0];
         end
         16'b0011_111z_zzzz_zzzz: begin  // move reg[b] to reg[a]
            op.kind  = op_move;
            op.src_a = ins[3:0];
            op.dst   = ins[7:4];
         end
         16'b0011_zzz0_zzzz_zzzz: begin  // memory bus access, address in reg[b]
            op.dst = ins[7:4];
            if (ins[11:9] == bus_cmd_write_w) begin
               op.kind = op_store_mem;
            end else if (ins[11:9] == bus_cmd_read_w) begin
               op.kind = op_load_mem;
            end
         end
         16'b1zzz_zzzz_zzzz_zzzz: begin  // three-register ops
            op.kind = op_alu;
            case (ins[14:12])
               3'h0:    op.alu_op = alu_add;
               3'h1:    op.alu_op = alu_sub;
               3'h4:    op.alu_op = alu_and;
               3'h5:    op.alu_op = alu_or;
               3'h6:    op.alu_op = alu_xor;
               3'h7:    op.alu_op = alu_cp;
               default: op.kind   = op_nop;  // MUL/DIV not built
            endcase
         end
         default: op.kind = op_nop;
      endcase
   end

endmodule

// ==== verilog/h80_pkg.sv ====
package h80_pkg;

   localparam int word_w   = 16;  // register, data and address width
   localparam int num_regs = 16;  // general registers

   typedef logic [word_w-1:0] word_t;
   typedef logic [3:0]        reg_num_t;

   // flag register bit positions
   localparam int flag_zero     = 0;
   localparam int flag_carry    = 1;
   localparam int flag_sign     = 2;
   localparam int flag_overflow = 3;

   typedef logic [3:0] flags_t;

   // word bus commands, as coded in ins[11:9]
   localparam logic [2:0] bus_cmd_write_w = 3'b010;
   localparam logic [2:0] bus_cmd_read_w  = 3'b011;

   typedef struct packed {
      logic  strobe;  // one-cycle request
      logic  write;   // 1 = store, 0 = read
      word_t addr;
      word_t wdata;
   } bus_req_t;

   typedef enum logic [2:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor,
      alu_cp
   } alu_op_t;

   typedef enum logic [2:0] {
      op_nop,
      op_halt,
      op_load_imm,
      op_load_mem,
      op_store_mem,
      op_move,
      op_jump,
      op_alu
   } op_kind_t;

   typedef struct packed {
      op_kind_t   kind;
      alu_op_t    alu_op;
      reg_num_t   dst;
      reg_num_t   src_a;
      reg_num_t   src_b;
      word_t      imm;       // already extended to word width
      logic       cond;      // jump depends on a flag
      logic [1:0] flag_sel;
      logic       sense;     // jump when flag equals this
   } op_t;

   typedef struct packed {
      word_t  result;
      flags_t flags;
   } alu_out_t;

   typedef struct packed {
      logic     en;
      reg_num_t num;
      word_t    data;
   } reg_wr_t;

endpackage

// ==== verilog/h80_regfile.sv ====
`timescale 1ns/1ps

module h80_regfile (
   input  logic              clk,
   input  logic              reset,
   input  h80_pkg::reg_num_t src_a,
   input  h80_pkg::reg_num_t src_b,
   input  h80_pkg::reg_wr_t  wr,
   output h80_pkg::word_t    rd_a,
   output h80_pkg::word_t    rd_b
);

   import h80_pkg::*;

   word_t regs [num_regs];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < num_regs; i++) begin
            regs[i] <= '0;
         end
      end else if (wr.en) begin
         regs[wr.num] <= wr.data;
      end
   end

   // asynchronous read ports
   assign rd_a = regs[src_a];
   assign rd_b = regs[src_b];

endmodule
